/* filelist.f */
rtl/alu_ft_pkg.sv
rtl/alu_ft_if.sv
rtl/alu_ft_issue.sv
rtl/alu_replica.sv
rtl/alu_ft_voter.sv
rtl/alu_ft_fault_mgr.sv
rtl/alu_ft_top.sv
test/alu_ft_assert.sv
test/alu_ft_tb.sv

/* rtl/alu_ft_fault_mgr.sv */
module alu_ft_fault_mgr (
	input  logic                      clk_i,
	input  logic                      rst_i,
	alu_health_if.manager             health,
	output alu_ft_pkg::replica_mask_t replica_en_o
);

	alu_ft_pkg::fm_state_t     state_q;
	alu_ft_pkg::fault_cnt_t    cnt_q [alu_ft_pkg::N_REPLICA];
	alu_ft_pkg::fault_cnt_t    cnt_nxt [alu_ft_pkg::N_REPLICA];
	// physical replica blamed by this vote
	alu_ft_pkg::replica_mask_t hit;
	logic                      sub_req;
	alu_ft_pkg::lane_sel_t     sub_lane;
	alu_ft_pkg::replica_mask_t sub_en;

	////////////////////////////////////////////////////////////
	// lane to replica mapping and counters
	////////////////////////////////////////////////////////////

	always_comb begin
		hit = '0;
		// a three-way split blames nobody
		if (health.vote_valid && !health.uncorrectable) begin
			for (int k = 0; k < alu_ft_pkg::N_LANE; k++) begin
				if (health.lane_err[k]) begin
					if (health.spare_lane == alu_ft_pkg::lane_sel_t'(k + 1)) begin
						hit[alu_ft_pkg::SPARE_IDX] = 1'b1;
					end else begin
						hit[k] = 1'b1;
					end
				end
			end
		end
	end

	// saturating increment
	always_comb begin
		for (int r = 0; r < alu_ft_pkg::N_REPLICA; r++) begin
			if (hit[r] && (cnt_q[r] != '1)) begin
				cnt_nxt[r] = cnt_q[r] + alu_ft_pkg::fault_cnt_t'(1);
			end else begin
				cnt_nxt[r] = cnt_q[r];
			end
		end
	end

	// lowest-numbered lane at the limit wins, loop runs downwards
	always_comb begin
		sub_req  = 1'b0;
		sub_lane = '0;
		sub_en   = alu_ft_pkg::RESET_EN;
		for (int k = alu_ft_pkg::N_LANE - 1; k >= 0; k--) begin
			if (cnt_nxt[k] >= alu_ft_pkg::FAULT_LIMIT) begin
				sub_req  = 1'b1;
				sub_lane = alu_ft_pkg::lane_sel_t'(k + 1);
				sub_en   = (alu_ft_pkg::RESET_EN
					| (alu_ft_pkg::replica_mask_t'(1) << alu_ft_pkg::SPARE_IDX))
					& ~(alu_ft_pkg::replica_mask_t'(1) << k);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// spare substitution
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q           <= alu_ft_pkg::FM_PRIMARY;
			health.spare_lane <= '0;
			replica_en_o      <= alu_ft_pkg::RESET_EN;
			for (int r = 0; r < alu_ft_pkg::N_REPLICA; r++) begin
				cnt_q[r] <= '0;
			end
		end else begin
			for (int r = 0; r < alu_ft_pkg::N_REPLICA; r++) begin
				cnt_q[r] <= cnt_nxt[r];
			end
			// single spare, so only one swap ever
			if (state_q == alu_ft_pkg::FM_PRIMARY && sub_req) begin
				health.spare_lane <= sub_lane;
				replica_en_o      <= sub_en;
				state_q           <= alu_ft_pkg::FM_SPARE;
			end
		end
	end

endmodule

/* rtl/alu_ft_if.sv */
// operation broadcast from the issue controller to all replicas
interface alu_op_if;
	// one-cycle launch pulse
	logic                      op_valid;
	alu_ft_pkg::alu_op_t       op;
	alu_ft_pkg::word_t         operand_a;
	alu_ft_pkg::word_t         operand_b;
	// per-replica SEU injection
	alu_ft_pkg::replica_mask_t fault_flip;

	modport issuer (
		output op_valid,
		output op,
		output operand_a,
		output operand_b,
		output fault_flip
	);

	modport replica (
		input op_valid,
		input op,
		input operand_a,
		input operand_b,
		input fault_flip
	);
endinterface

// vote outcome towards the fault manager, lane mapping back to the voter
interface alu_health_if;
	logic                   vote_valid;
	// one-hot erring lane, zero when no clear minority
	alu_ft_pkg::lane_mask_t lane_err;
	// all three lanes disagree
	logic                   uncorrectable;
	alu_ft_pkg::lane_sel_t  spare_lane;

	modport voter (
		output vote_valid,
		output lane_err,
		output uncorrectable,
		input  spare_lane
	);

	modport manager (
		input  vote_valid,
		input  lane_err,
		input  uncorrectable,
		output spare_lane
	);
endinterface

/* rtl/alu_ft_issue.sv */
module alu_ft_issue (
	input  logic                      clk_i,
	input  logic                      rst_i,
	input  logic                      req_i,
	input  alu_ft_pkg::alu_op_t       op_i,
	input  alu_ft_pkg::word_t         operand_a_i,
	input  alu_ft_pkg::word_t         operand_b_i,
	input  alu_ft_pkg::replica_mask_t fault_flip_i,
	input  logic                      done_i,
	output logic                      ack_o,
	alu_op_if.issuer                  op_bus
);

	alu_ft_pkg::issue_state_t state_q;
	// one cycle between capture and launch
	logic                     launch_q;
	logic                     accept;

	// new request only taken while idle
	assign accept = (state_q == alu_ft_pkg::IS_IDLE) && req_i;

	////////////////////////////////////////////////////////////
	// handshake FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q         <= alu_ft_pkg::IS_IDLE;
			launch_q        <= 1'b0;
			op_bus.op_valid <= 1'b0;
			ack_o           <= 1'b0;
		end else begin
			// launch pulse trails the capture by one edge
			launch_q        <= accept;
			op_bus.op_valid <= launch_q;
			case (state_q)
				alu_ft_pkg::IS_IDLE: begin
					if (req_i) begin
						state_q <= alu_ft_pkg::IS_BUSY;
					end
				end
				alu_ft_pkg::IS_BUSY: begin
					// voter finished, results on the outputs
					if (done_i) begin
						ack_o   <= 1'b1;
						state_q <= alu_ft_pkg::IS_ACK;
					end
				end
				alu_ft_pkg::IS_ACK: begin
					// held here as long as the requester keeps req high
					if (!req_i) begin
						ack_o   <= 1'b0;
						state_q <= alu_ft_pkg::IS_IDLE;
					end
				end
				default: begin
					state_q <= alu_ft_pkg::IS_IDLE;
				end
			endcase
		end
	end

	// operand capture on acceptance
	always_ff @(posedge clk_i) begin
		if (accept) begin
			op_bus.op         <= op_i;
			op_bus.operand_a  <= operand_a_i;
			op_bus.operand_b  <= operand_b_i;
			op_bus.fault_flip <= fault_flip_i;
		end
	end

endmodule

/* rtl/alu_ft_pkg.sv */
package alu_ft_pkg;

	////////////////////////////////////////////////////////////
	// datapath
	////////////////////////////////////////////////////////////

	// operand and result width
	localparam int DATA_W = 32;
	typedef logic [DATA_W-1:0] word_t;

	// reduced operation set, 3-bit encoding
	typedef enum logic [2:0] {
		OP_ADD  = 3'd0,
		OP_SUB  = 3'd1,
		OP_AND  = 3'd2,
		OP_OR   = 3'd3,
		OP_XOR  = 3'd4,
		OP_SLT  = 3'd5,
		OP_SLTU = 3'd6,
		OP_EQ   = 3'd7
	} alu_op_t;

	////////////////////////////////////////////////////////////
	// redundancy
	////////////////////////////////////////////////////////////

	// three active replicas plus one cold spare
	localparam int N_REPLICA = 4;
	localparam int N_LANE    = 3;
	localparam int SPARE_IDX = 3;

	typedef logic [N_REPLICA-1:0] replica_mask_t;
	typedef logic [N_LANE-1:0]    lane_mask_t;
	// 0 = no substitution, 1..3 = spare sits in lane 0..2
	typedef logic [1:0]           lane_sel_t;

	// replica i flips bit i of its result when injected
	localparam word_t FAULT_PATTERN = 32'h0000_0001;

	// disagreements tolerated before removal
	typedef logic [1:0] fault_cnt_t;
	localparam fault_cnt_t FAULT_LIMIT = 2'd2;

	typedef enum logic {
		FM_PRIMARY,
		FM_SPARE
	} fm_state_t;

	// replicas 0..2 active, spare gated off
	localparam replica_mask_t RESET_EN = 4'b0111;

	// request handshake states
	typedef enum logic [1:0] {
		IS_IDLE,
		IS_BUSY,
		IS_ACK
	} issue_state_t;

endpackage

/* rtl/alu_ft_top.sv */
module alu_ft_top (
	input  logic                      clk_i,
	input  logic                      rst_i,
	input  logic                      req_i,
	input  alu_ft_pkg::alu_op_t       op_i,
	input  alu_ft_pkg::word_t         operand_a_i,
	input  alu_ft_pkg::word_t         operand_b_i,
	input  alu_ft_pkg::replica_mask_t fault_flip_i,
	output logic                      ack_o,
	output alu_ft_pkg::word_t         result_o,
	output logic                      comparison_o,
	output logic                      err_detected_o,
	output logic                      err_corrected_o,
	output alu_ft_pkg::replica_mask_t replica_en_o
);

	alu_op_if     op_bus ();
	alu_health_if health ();

	// replica outputs, indexed by physical replica
	alu_ft_pkg::word_t [alu_ft_pkg::N_REPLICA-1:0] rep_result;
	alu_ft_pkg::replica_mask_t                    rep_cmp;
	alu_ft_pkg::replica_mask_t                    rep_valid;
	logic                                         vote_done;

	alu_ft_issue issue_inst (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.req_i        (req_i),
		.op_i         (op_i),
		.operand_a_i  (operand_a_i),
		.operand_b_i  (operand_b_i),
		.fault_flip_i (fault_flip_i),
		.done_i       (vote_done),
		.ack_o        (ack_o),
		.op_bus       (op_bus.issuer)
	);

	////////////////////////////////////////////////////////////
	// four lockstep replicas
	////////////////////////////////////////////////////////////

	for (genvar i = 0; i < alu_ft_pkg::N_REPLICA; i++) begin : g_replica
		alu_replica #(
			.REPLICA_IDX (i)
		) replica_inst (
			.clk_i       (clk_i),
			.rst_i       (rst_i),
			.en_i        (replica_en_o[i]),
			.op_bus      (op_bus.replica),
			.result_o    (rep_result[i]),
			.cmp_o       (rep_cmp[i]),
			.res_valid_o (rep_valid[i])
		);
	end

	// all replicas launch together, replica 0 paces the vote
	alu_ft_voter voter_inst (
		.clk_i           (clk_i),
		.rst_i           (rst_i),
		.result_i        (rep_result),
		.cmp_i           (rep_cmp),
		.res_valid_i     (rep_valid[0]),
		.health          (health.voter),
		.done_o          (vote_done),
		.result_o        (result_o),
		.comparison_o    (comparison_o),
		.err_detected_o  (err_detected_o),
		.err_corrected_o (err_corrected_o)
	);

	alu_ft_fault_mgr fault_mgr_inst (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.health       (health.manager),
		.replica_en_o (replica_en_o)
	);

endmodule

/* rtl/alu_ft_voter.sv */
module alu_ft_voter (
	input  logic                                         clk_i,
	input  logic                                         rst_i,
	input  alu_ft_pkg::word_t [alu_ft_pkg::N_REPLICA-1:0] result_i,
	input  alu_ft_pkg::replica_mask_t                    cmp_i,
	input  logic                                         res_valid_i,
	alu_health_if.voter                                  health,
	output logic                                         done_o,
	output alu_ft_pkg::word_t                            result_o,
	output logic                                         comparison_o,
	output logic                                         err_detected_o,
	output logic                                         err_corrected_o
);

	// comparison bit on top of the result word
	logic [alu_ft_pkg::DATA_W:0] lane_word [alu_ft_pkg::N_LANE];
	logic [alu_ft_pkg::DATA_W:0] voted_word;
	logic                        eq01;
	logic                        eq02;
	logic                        eq12;
	logic                        det;
	logic                        cor;
	logic                        no_major;
	alu_ft_pkg::lane_mask_t      err_lane;

	////////////////////////////////////////////////////////////
	// lane mux, spare takes over the lane named by spare_lane
	////////////////////////////////////////////////////////////

	always_comb begin
		for (int k = 0; k < alu_ft_pkg::N_LANE; k++) begin
			if (health.spare_lane == alu_ft_pkg::lane_sel_t'(k + 1)) begin
				lane_word[k] = {cmp_i[alu_ft_pkg::SPARE_IDX], result_i[alu_ft_pkg::SPARE_IDX]};
			end else begin
				lane_word[k] = {cmp_i[k], result_i[k]};
			end
		end
	end

	assign eq01 = (lane_word[0] == lane_word[1]);
	assign eq02 = (lane_word[0] == lane_word[2]);
	assign eq12 = (lane_word[1] == lane_word[2]);

	// majority decision
	always_comb begin
		voted_word = lane_word[0];
		det        = 1'b0;
		cor        = 1'b0;
		no_major   = 1'b0;
		err_lane   = '0;
		if (eq01 && eq02) begin
			// unanimous
			voted_word = lane_word[0];
		end else if (eq01) begin
			// lane 2 is the odd one
			det      = 1'b1;
			cor      = 1'b1;
			err_lane = 3'b100;
		end else if (eq02) begin
			det      = 1'b1;
			cor      = 1'b1;
			err_lane = 3'b010;
		end else if (eq12) begin
			// lanes 1 and 2 outvote lane 0
			voted_word = lane_word[1];
			det        = 1'b1;
			cor        = 1'b1;
			err_lane   = 3'b001;
		end else begin
			// three-way split, fall back on lane 0
			det      = 1'b1;
			no_major = 1'b1;
		end
	end

	// outputs held until the next vote
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			done_o               <= 1'b0;
			health.vote_valid    <= 1'b0;
			health.lane_err      <= '0;
			health.uncorrectable <= 1'b0;
			result_o             <= '0;
			comparison_o         <= 1'b0;
			err_detected_o       <= 1'b0;
			err_corrected_o      <= 1'b0;
		end else begin
			done_o            <= res_valid_i;
			health.vote_valid <= res_valid_i;
			if (res_valid_i) begin
				{comparison_o, result_o} <= voted_word;
				err_detected_o           <= det;
				err_corrected_o          <= cor;
				health.lane_err          <= err_lane;
				health.uncorrectable     <= no_major;
			end
		end
	end

endmodule

/* rtl/alu_replica.sv */
module alu_replica #(
	parameter int REPLICA_IDX = 0
) (
	input  logic              clk_i,
	input  logic              rst_i,
	input  logic              en_i,
	alu_op_if.replica         op_bus,
	output alu_ft_pkg::word_t result_o,
	output logic              cmp_o,
	output logic              res_valid_o
);

	alu_ft_pkg::word_t alu_res;
	alu_ft_pkg::word_t flip_mask;
	logic              alu_cmp;
	logic              lt_s;
	logic              lt_u;

	// per-replica SEU pattern, unique bit position
	assign flip_mask = op_bus.fault_flip[REPLICA_IDX] ?
		(alu_ft_pkg::FAULT_PATTERN << REPLICA_IDX) : '0;

	assign lt_s = $signed(op_bus.operand_a) < $signed(op_bus.operand_b);
	assign lt_u = op_bus.operand_a < op_bus.operand_b;

	always_comb begin
		alu_res = '0;
		alu_cmp = 1'b0;
		case (op_bus.op)
			alu_ft_pkg::OP_ADD: alu_res = op_bus.operand_a + op_bus.operand_b;
			alu_ft_pkg::OP_SUB: alu_res = op_bus.operand_a - op_bus.operand_b;
			alu_ft_pkg::OP_AND: alu_res = op_bus.operand_a & op_bus.operand_b;
			alu_ft_pkg::OP_OR:  alu_res = op_bus.operand_a | op_bus.operand_b;
			alu_ft_pkg::OP_XOR: alu_res = op_bus.operand_a ^ op_bus.operand_b;
			// set-less-than yields 0/1 word plus flag
			alu_ft_pkg::OP_SLT: begin
				alu_res = alu_ft_pkg::word_t'(lt_s);
				alu_cmp = lt_s;
			end
			alu_ft_pkg::OP_SLTU: begin
				alu_res = alu_ft_pkg::word_t'(lt_u);
				alu_cmp = lt_u;
			end
			// equality only drives the flag
			alu_ft_pkg::OP_EQ: alu_cmp = (op_bus.operand_a == op_bus.operand_b);
			default: alu_res = '0;
		endcase
	end

	// valid follows the launch on every replica, even a gated one
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			res_valid_o <= 1'b0;
		end else begin
			res_valid_o <= op_bus.op_valid;
		end
	end

	// en low freezes the result, like a gated clock
	always_ff @(posedge clk_i) begin
		if (op_bus.op_valid && en_i) begin
			result_o <= alu_res ^ flip_mask;
			cmp_o    <= alu_cmp;
		end
	end

endmodule

/* test/alu_ft_assert.sv */
module alu_ft_assert (
	input logic                      clk_i,
	input logic                      rst_i,
	input logic                      req_i,
	input logic                      accept_i,
	input logic                      ack_o,
	input logic                      err_detected_o,
	input logic                      err_corrected_o,
	input alu_ft_pkg::replica_mask_t replica_en_o
);
	timeunit 1ns;
	timeprecision 1ps;

	// read back by the testbench
	int fail_cnt = 0;

	// accepted request, ack exactly four edges later
	ack_latency: assert property (@(posedge clk_i) disable iff (rst_i)
		accept_i |=> !ack_o [*4] ##1 ack_o)
		else begin
			fail_cnt++;
			$error("ack_o did not rise four cycles after the request was accepted");
		end

	// release phase
	ack_release: assert property (@(posedge clk_i) disable iff (rst_i)
		ack_o && !req_i |=> !ack_o)
		else begin
			fail_cnt++;
			$error("ack_o did not fall one cycle after req_i dropped");
		end

	// always three replicas clocked
	three_enabled: assert property (@(posedge clk_i) disable iff (rst_i)
		$countones(replica_en_o) == 3)
		else begin
			fail_cnt++;
			$error("replica_en_o does not have exactly three bits set");
		end

	corrected_implies_detected: assert property (@(posedge clk_i) disable iff (rst_i)
		err_corrected_o |-> err_detected_o)
		else begin
			fail_cnt++;
			$error("err_corrected_o high without err_detected_o");
		end

endmodule

bind alu_ft_top alu_ft_assert assert_inst (
	.clk_i           (clk_i),
	.rst_i           (rst_i),
	.req_i           (req_i),
	.accept_i        (issue_inst.accept),
	.ack_o           (ack_o),
	.err_detected_o  (err_detected_o),
	.err_corrected_o (err_corrected_o),
	.replica_en_o    (replica_en_o)
);

/* test/alu_ft_tb.sv */
module alu_ft_tb;
	timeunit 1ns;
	timeprecision 1ps;

	// run length and wait limits
	localparam int N_OPS       = 40;
	localparam int ACK_TIMEOUT = 20;
	localparam int REQ_TO_ACK  = 4;

	logic                      clk_i;
	logic                      rst_i;
	logic                      req_i;
	alu_ft_pkg::alu_op_t       op_i;
	alu_ft_pkg::word_t         operand_a_i;
	alu_ft_pkg::word_t         operand_b_i;
	alu_ft_pkg::replica_mask_t fault_flip_i;
	logic                      ack_o;
	alu_ft_pkg::word_t         result_o;
	logic                      comparison_o;
	logic                      err_detected_o;
	logic                      err_corrected_o;
	alu_ft_pkg::replica_mask_t replica_en_o;

	integer seed;

	// reference model state
	alu_ft_pkg::replica_mask_t m_en;
	alu_ft_pkg::fault_cnt_t    m_cnt [alu_ft_pkg::N_REPLICA];
	alu_ft_pkg::lane_sel_t     m_spare_lane;
	logic                      m_spare_used;
	// expected outputs of the current operation
	alu_ft_pkg::word_t         exp_result;
	logic                      exp_cmp;
	logic                      exp_det;
	logic                      exp_cor;

	alu_ft_top alu_ft_top_inst (.*);

	// 20 ns period
	always #10 clk_i = ~clk_i;

	////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////

	task automatic stop_on_error();
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check_word(input string what, input alu_ft_pkg::word_t got,
		input alu_ft_pkg::word_t exp);
		if (got !== exp) begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_en(input string what, input alu_ft_pkg::replica_mask_t got,
		input alu_ft_pkg::replica_mask_t exp);
		if (got !== exp) begin
			$display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_cycles(input string what, input int got, input int exp);
		if (got != exp) begin
			$display("Error at %0t ns: %s is %0d cycles, expected %0d", $time, what, got, exp);
			stop_on_error();
		end
	endtask

	// bound assertions count their failures
	task automatic poll_assertions();
		if (alu_ft_top_inst.assert_inst.fail_cnt != 0) begin
			$display("a bound assertion on the DUT failed, see the messages above");
			stop_on_error();
		end
	endtask

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////

	// fault-free value with the comparison bit on top
	function automatic logic [alu_ft_pkg::DATA_W:0] ref_alu(input alu_ft_pkg::alu_op_t op,
		input alu_ft_pkg::word_t a, input alu_ft_pkg::word_t b);
		alu_ft_pkg::word_t res;
		logic              cmp;
		res = '0;
		cmp = 1'b0;
		case (op)
			alu_ft_pkg::OP_ADD: res = a + b;
			alu_ft_pkg::OP_SUB: res = a - b;
			alu_ft_pkg::OP_AND: res = a & b;
			alu_ft_pkg::OP_OR:  res = a | b;
			alu_ft_pkg::OP_XOR: res = a ^ b;
			alu_ft_pkg::OP_SLT: begin
				cmp = $signed(a) < $signed(b);
				res = {{(alu_ft_pkg::DATA_W-1){1'b0}}, cmp};
			end
			alu_ft_pkg::OP_SLTU: begin
				cmp = a < b;
				res = {{(alu_ft_pkg::DATA_W-1){1'b0}}, cmp};
			end
			// flag only with a zero word
			alu_ft_pkg::OP_EQ: cmp = (a == b);
			default: res = '0;
		endcase
		return {cmp, res};
	endfunction

	// lanes, vote, counters and spare swap for one operation
	task automatic predict(input alu_ft_pkg::alu_op_t op, input alu_ft_pkg::word_t a,
		input alu_ft_pkg::word_t b, input alu_ft_pkg::replica_mask_t flip);
		logic [alu_ft_pkg::DATA_W:0] good;
		logic [alu_ft_pkg::DATA_W:0] lane [alu_ft_pkg::N_LANE];
		logic [alu_ft_pkg::DATA_W:0] vote;
		int                          phys [alu_ft_pkg::N_LANE];
		int                          bad_lane;
		int                          sel;
		good     = ref_alu(op, a, b);
		bad_lane = -1;
		sel      = -1;
		for (int k = 0; k < alu_ft_pkg::N_LANE; k++) begin
			// spare stands in for the lane it replaced
			if (m_spare_lane == alu_ft_pkg::lane_sel_t'(k + 1)) begin
				phys[k] = alu_ft_pkg::SPARE_IDX;
			end else begin
				phys[k] = k;
			end
			lane[k] = good;
			if (flip[phys[k]]) begin
				lane[k] = good ^ {1'b0, alu_ft_pkg::FAULT_PATTERN << phys[k]};
			end
		end
		// three-way split falls back on lane 0
		vote = lane[0];
		if (lane[1] == lane[2] && lane[0] != lane[1]) begin
			vote     = lane[1];
			bad_lane = 0;
		end else if (lane[0] == lane[2] && lane[1] != lane[0]) begin
			bad_lane = 1;
		end else if (lane[0] == lane[1] && lane[2] != lane[0]) begin
			bad_lane = 2;
		end
		exp_det                  = !(lane[0] == lane[1] && lane[1] == lane[2]);
		exp_cor                  = (bad_lane >= 0);
		{exp_cmp, exp_result}    = vote;
		// saturating count on the physical replica
		if (bad_lane >= 0 && m_cnt[phys[bad_lane]] != '1) begin
			m_cnt[phys[bad_lane]] = m_cnt[phys[bad_lane]] + 1'b1;
		end
		// single spare goes to the lowest lane at the limit
		if (!m_spare_used) begin
			for (int k = 0; k < alu_ft_pkg::N_LANE; k++) begin
				if (sel < 0 && m_cnt[k] >= alu_ft_pkg::FAULT_LIMIT) begin
					sel = k;
				end
			end
			if (sel >= 0) begin
				m_spare_used                 = 1'b1;
				m_spare_lane                 = alu_ft_pkg::lane_sel_t'(sel + 1);
				m_en[sel]                    = 1'b0;
				m_en[alu_ft_pkg::SPARE_IDX] = 1'b1;
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// handshake driver
	////////////////////////////////////////////////////////////

	task automatic run_op(input alu_ft_pkg::alu_op_t op, input alu_ft_pkg::word_t a,
		input alu_ft_pkg::word_t b, input alu_ft_pkg::replica_mask_t flip);
		int lows;
		int highs;
		int hold;
		@(posedge clk_i);
		req_i        <= 1'b1;
		op_i         <= op;
		operand_a_i  <= a;
		operand_b_i  <= b;
		fault_flip_i <= flip;
		predict(op, a, b, flip);
		// first low sample comes before the sampling edge
		lows = 0;
		@(negedge clk_i);
		while (!ack_o) begin
			lows++;
			if (lows > ACK_TIMEOUT) begin
				$display("ack_o never rose after the request was raised");
				stop_on_error();
			end
			@(negedge clk_i);
		end
		check_cycles("request to ack latency", lows - 1, REQ_TO_ACK);
		check_word("result_o", result_o, exp_result);
		check_flag("comparison_o", comparison_o, exp_cmp);
		check_flag("err_detected_o", err_detected_o, exp_det);
		check_flag("err_corrected_o", err_corrected_o, exp_cor);
		check_en("replica_en_o", replica_en_o, m_en);
		// ack stays up while the requester lingers
		hold = {$random(seed)} % 4;
		repeat (hold) begin
			@(negedge clk_i);
			check_flag("ack_o while req_i held", ack_o, 1'b1);
		end
		@(posedge clk_i);
		req_i <= 1'b0;
		highs = 0;
		@(negedge clk_i);
		while (ack_o) begin
			highs++;
			if (highs > ACK_TIMEOUT) begin
				$display("ack_o never fell after the request was dropped");
				stop_on_error();
			end
			@(negedge clk_i);
		end
		check_cycles("req drop to ack fall", highs, 1);
		poll_assertions();
	endtask

	// random operands with equal pairs now and then
	task automatic random_op(input alu_ft_pkg::replica_mask_t flip);
		alu_ft_pkg::alu_op_t op;
		alu_ft_pkg::word_t   a;
		alu_ft_pkg::word_t   b;
		op = alu_ft_pkg::alu_op_t'(3'($random(seed)));
		a  = $random(seed);
		b  = $random(seed);
		if (($random(seed) & 3) == 0) begin
			b = a;
		end
		run_op(op, a, b, flip);
	endtask

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	initial begin
		int                        victim;
		int                        guard;
		int                        pick_a;
		int                        pick_b;
		int                        active [alu_ft_pkg::N_LANE];
		int                        n_act;
		alu_ft_pkg::replica_mask_t exp_en;
		seed         = 32'h4189_a0bf;
		clk_i        = 1'b0;
		rst_i        = 1'b1;
		req_i        = 1'b0;
		op_i         = alu_ft_pkg::OP_ADD;
		operand_a_i  = '0;
		operand_b_i  = '0;
		fault_flip_i = '0;
		m_en         = alu_ft_pkg::RESET_EN;
		m_spare_lane = '0;
		m_spare_used = 1'b0;
		for (int r = 0; r < alu_ft_pkg::N_REPLICA; r++) begin
			m_cnt[r] = '0;
		end
		repeat (4) @(posedge clk_i);
		rst_i <= 1'b0;
		@(negedge clk_i);
		check_flag("ack_o after reset", ack_o, 1'b0);
		check_flag("err_detected_o after reset", err_detected_o, 1'b0);
		check_flag("err_corrected_o after reset", err_corrected_o, 1'b0);
		check_word("result_o after reset", result_o, '0);
		check_flag("comparison_o after reset", comparison_o, 1'b0);
		check_en("replica_en_o after reset", replica_en_o, alu_ft_pkg::RESET_EN);

		// fault-free traffic
		repeat (N_OPS) random_op('0);

		// one corrected fault on each active replica
		for (int r = 0; r < alu_ft_pkg::N_LANE; r++) begin
			random_op(alu_ft_pkg::replica_mask_t'(1) << r);
		end

		// hammer one replica until the spare takes over
		victim = {$random(seed)} % alu_ft_pkg::N_LANE;
		guard  = 0;
		while (replica_en_o[victim]) begin
			if (guard > alu_ft_pkg::FAULT_LIMIT + 2) begin
				$display("replica %0d was never removed after repeated faults", victim);
				stop_on_error();
			end
			guard++;
			random_op(alu_ft_pkg::replica_mask_t'(1) << victim);
		end
		// victim gated off and spare clocked in its place
		exp_en                        = alu_ft_pkg::RESET_EN;
		exp_en[victim]                = 1'b0;
		exp_en[alu_ft_pkg::SPARE_IDX] = 1'b1;
		check_en("replica_en_o after substitution", replica_en_o, exp_en);
		repeat (10) random_op('0);

		// removed replica is out of the vote
		random_op(alu_ft_pkg::replica_mask_t'(1) << victim);
		check_flag("err_detected_o, fault on removed replica", err_detected_o, 1'b0);

		// two active replicas hit at once
		n_act = 0;
		for (int r = 0; r < alu_ft_pkg::N_REPLICA; r++) begin
			if (r != victim) begin
				active[n_act] = r;
				n_act++;
			end
		end
		pick_a = {$random(seed)} % alu_ft_pkg::N_LANE;
		pick_b = (pick_a + 1 + ({$random(seed)} % 2)) % alu_ft_pkg::N_LANE;
		random_op((alu_ft_pkg::replica_mask_t'(1) << active[pick_a])
			| (alu_ft_pkg::replica_mask_t'(1) << active[pick_b]));
		check_flag("err_detected_o, double fault", err_detected_o, 1'b1);
		check_flag("err_corrected_o, double fault", err_corrected_o, 1'b0);

		// any fault mix once the spare is spent
		repeat (N_OPS) random_op(alu_ft_pkg::replica_mask_t'($random(seed)));

		if (alu_ft_top_inst.assert_inst.fail_cnt != 0) begin
			$display("a bound assertion on the DUT failed during the run");
			stop_on_error();
		end else begin
			$display("Everything OK");
			$finish;
		end
	end

endmodule
